//--- Bender.yml
package:
  name: sd_bringup

dependencies: {}

sources:
  # design, package first
  - logic/sd_bringup_pkg.sv
  - logic/board_timebase.sv
  - logic/spi_byte_shifter.sv
  - logic/sd_cmd_sequencer.sv
  - logic/hex_console_writer.sv
  - logic/wb_console_master.sv
  - logic/sd_bringup_top.sv

  # testbench and card model
  - target: simulation
    files:
      - verif/sd_card_model.sv
      - verif/sd_bringup_tb.sv

//--- logic/board_timebase.sv
`timescale 1ns/1ps

module board_timebase #(
    parameter int tick_div        = 256,
    parameter int heartbeat_width = 24
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic tick,
    output logic LEDR0
);

    localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [div_w-1:0]           div_cnt;
    logic [heartbeat_width-1:0] blink_cnt;

    // led is the counter msb, toggles every half wrap
    assign LEDR0 = blink_cnt[heartbeat_width-1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt   <= '0;
            tick      <= 1'b0;
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
            // one clock pulse per tick_div clocks
            if (div_cnt == div_w'(tick_div - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

//--- logic/hex_console_writer.sv
`timescale 1ns/1ps

module hex_console_writer (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  card_ready,
    input  logic                  data_valid,
    input  sd_bringup_pkg::byte_t data_byte,
    output logic                  data_ready,
    output logic                  char_valid,
    output sd_bringup_pkg::byte_t char_byte,
    input  logic                  char_ready
);

    typedef enum logic [2:0] {H_WAIT, H_BANNER, H_IDLE, H_HI, H_LO} hex_state_t;

    hex_state_t            state;
    sd_bringup_pkg::byte_t cur;
    sd_bringup_pkg::byte_t prev;
    logic                  sig_seen;

    // nibble to upper-case ascii
    function automatic sd_bringup_pkg::byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + 8'(nib);
        end
        return 8'h37 + 8'(nib);
    endfunction

    assign data_ready = (state == H_IDLE);
    assign char_valid = (state == H_BANNER) || (state == H_HI) || (state == H_LO);

    always_comb begin
        case (state)
            H_BANNER: char_byte = "K";
            H_HI:     char_byte = hex_char(cur[7:4]);
            default:  char_byte = hex_char(cur[3:0]);
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= H_WAIT;
            prev     <= 8'h00;
            sig_seen <= 1'b0;
        end else begin
            case (state)
                H_WAIT:   if (card_ready) state <= H_BANNER;
                H_BANNER: if (char_ready) state <= H_IDLE;
                // after the signature bytes are taken and dropped
                H_IDLE:   if (data_valid && !sig_seen) state <= H_HI;
                H_HI:     if (char_ready) state <= H_LO;
                H_LO: if (char_ready) begin
                    state <= H_IDLE;
                    prev  <= cur;
                    if (prev == sd_bringup_pkg::BOOT_SIG_HI &&
                        cur == sd_bringup_pkg::BOOT_SIG_LO) begin
                        sig_seen <= 1'b1;
                    end
                end
                default: state <= H_WAIT;
            endcase
        end
    end

    // byte being printed
    always_ff @(posedge CLOCK_50) begin
        if (state == H_IDLE && data_valid) begin
            cur <= data_byte;
        end
    end

endmodule

//--- logic/sd_bringup_pkg.sv
package sd_bringup_pkg;

    // ==============================
    // types
    // ==============================

    // one spi or sector byte
    typedef logic [7:0] byte_t;

    // card side lines, cs_n driven by the sequencer
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    // console bus, master side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] adr;
        byte_t      dat;
    } wb_m2s_t;

    // framed as 01 + index, arg, crc + stop bit
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic [6:0]  crc;
    } sd_cmd_t;

    // ==============================
    // constants
    // ==============================

    // crc fields give 0x95, 0x65, 0x01 and 0x55 once the stop bit is added
    localparam sd_cmd_t SD_CMD0   = '{index: 6'd0,  arg: 32'h0000_0000, crc: 7'h4A};
    localparam sd_cmd_t SD_CMD55  = '{index: 6'd55, arg: 32'h0000_0000, crc: 7'h32};
    localparam sd_cmd_t SD_ACMD41 = '{index: 6'd41, arg: 32'h4000_0000, crc: 7'h00};
    localparam sd_cmd_t SD_CMD17  = '{index: 6'd17, arg: 32'h0000_0000, crc: 7'h2A};

    localparam byte_t R1_IDLE    = 8'h01;
    localparam byte_t R1_READY   = 8'h00;
    localparam byte_t DATA_TOKEN = 8'hFE;

    localparam int SECTOR_BYTES = 512;

    // boot signature at the end of sector 0
    localparam byte_t BOOT_SIG_HI = 8'h55;
    localparam byte_t BOOT_SIG_LO = 8'hAA;

endpackage

//--- logic/sd_bringup_top.sv
`timescale 1ns/1ps

module sd_bringup_top #(
    parameter int tick_div        = 256,
    parameter int heartbeat_width = 24,
    parameter int console_adr     = 0
) (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    output logic                    LEDR0,
    output logic                    SD_CLK,
    output logic                    SD_CMD,
    input  logic                    SD_DAT0,
    output logic                    SD_DAT3,
    output sd_bringup_pkg::wb_m2s_t console_wb,
    input  logic                    console_ack
);

    // ==============================
    // internal wiring
    // ==============================
    logic                      tick;
    wire sd_bringup_pkg::spi_pins_t spi;

    // sequencer <-> shifter
    logic                      xfer_req;
    logic                      xfer_done;
    sd_bringup_pkg::byte_t     tx_byte;
    sd_bringup_pkg::byte_t     rx_byte;

    // sequencer -> hex writer
    logic                      card_ready;
    logic                      data_valid;
    logic                      data_ready;
    sd_bringup_pkg::byte_t     data_byte;

    // hex writer -> console master
    logic                      char_valid;
    logic                      char_ready;
    sd_bringup_pkg::byte_t     char_byte;

    // spi lines out to the card socket
    assign SD_CLK  = spi.sclk;
    assign SD_CMD  = spi.mosi;
    assign SD_DAT3 = spi.cs_n;

    board_timebase #(
        .tick_div        (tick_div),
        .heartbeat_width (heartbeat_width)
    ) u_timebase (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tick     (tick),
        .LEDR0    (LEDR0)
    );

    spi_byte_shifter u_shifter (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .tick      (tick),
        .xfer_req  (xfer_req),
        .tx_byte   (tx_byte),
        .SD_DAT0   (SD_DAT0),
        .sclk      (spi.sclk),
        .mosi      (spi.mosi),
        .xfer_done (xfer_done),
        .rx_byte   (rx_byte)
    );

    sd_cmd_sequencer u_sequencer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .xfer_done  (xfer_done),
        .rx_byte    (rx_byte),
        .xfer_req   (xfer_req),
        .cs_n       (spi.cs_n),
        .tx_byte    (tx_byte),
        .card_ready (card_ready),
        .data_valid (data_valid),
        .data_byte  (data_byte),
        .data_ready (data_ready)
    );

    hex_console_writer u_hex (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .card_ready (card_ready),
        .data_valid (data_valid),
        .data_byte  (data_byte),
        .data_ready (data_ready),
        .char_valid (char_valid),
        .char_byte  (char_byte),
        .char_ready (char_ready)
    );

    wb_console_master #(
        .console_adr (console_adr)
    ) u_console (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .char_valid  (char_valid),
        .char_byte   (char_byte),
        .char_ready  (char_ready),
        .console_wb  (console_wb),
        .console_ack (console_ack)
    );

endmodule

//--- logic/sd_cmd_sequencer.sv
`timescale 1ns/1ps

module sd_cmd_sequencer (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  xfer_done,
    input  sd_bringup_pkg::byte_t rx_byte,
    output logic                  xfer_req,
    output logic                  cs_n,
    output sd_bringup_pkg::byte_t tx_byte,
    output logic                  card_ready,
    output logic                  data_valid,
    output sd_bringup_pkg::byte_t data_byte,
    input  logic                  data_ready
);

    typedef enum logic [2:0] {
        ST_DUMMY,   // 10 fill bytes, cs high
        ST_FRAME,   // 6 command bytes
        ST_R1,      // poll for r1
        ST_TOKEN,   // poll for data token
        ST_DATA,    // fetch one sector byte
        ST_HOLD,    // byte offered downstream
        ST_CRC,     // drop 2 crc bytes
        ST_PARK
    } seq_state_t;

    seq_state_t              state;
    sd_bringup_pkg::sd_cmd_t cmd;
    logic [2:0]              frame_idx;
    logic [9:0]              cnt;
    logic [47:0]             frame;
    logic                    issue;

    // start bits, index, arg, crc, stop bit
    assign frame = {2'b01, cmd.index, cmd.arg, cmd.crc, 1'b1};

    // only the command frame carries data, all else is 0xff fill
    always_comb begin
        if (state == ST_FRAME) begin
            tx_byte = frame[8 * (5 - int'(frame_idx)) +: 8];
        end else begin
            tx_byte = 8'hFF;
        end
    end

    // no spi traffic while a byte waits downstream or when finished
    assign issue = (state != ST_HOLD) && (state != ST_PARK);

    // shifter keeps the last byte until the next request
    assign data_valid = (state == ST_HOLD);
    assign data_byte  = rx_byte;

    // ==============================
    // bring-up fsm
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_DUMMY;
            cmd        <= sd_bringup_pkg::SD_CMD0;
            frame_idx  <= 3'd0;
            cnt        <= 10'd0;
            xfer_req   <= 1'b0;
            cs_n       <= 1'b1;
            card_ready <= 1'b0;
        end else begin
            // request held until done, re-raised a cycle later
            if (xfer_done) begin
                xfer_req <= 1'b0;
            end else if (!xfer_req && issue) begin
                xfer_req <= 1'b1;
            end

            case (state)
                ST_DUMMY: if (xfer_done) begin
                    cnt <= cnt + 10'd1;
                    // 80 clocks done, select card
                    if (cnt == 10'd9) begin
                        cnt   <= 10'd0;
                        cs_n  <= 1'b0;
                        state <= ST_FRAME;
                    end
                end
                ST_FRAME: if (xfer_done) begin
                    frame_idx <= frame_idx + 3'd1;
                    if (frame_idx == 3'd5) begin
                        frame_idx <= 3'd0;
                        state     <= ST_R1;
                    end
                end
                // r1 has msb clear, 0xff means still busy
                ST_R1: if (xfer_done && !rx_byte[7]) begin
                    state <= ST_FRAME;
                    if (cmd == sd_bringup_pkg::SD_CMD0) begin
                        if (rx_byte == sd_bringup_pkg::R1_IDLE) begin
                            cmd <= sd_bringup_pkg::SD_CMD55;
                        end
                    end else if (cmd == sd_bringup_pkg::SD_CMD55) begin
                        cmd <= sd_bringup_pkg::SD_ACMD41;
                    end else if (cmd == sd_bringup_pkg::SD_ACMD41) begin
                        // still idle means another cmd55/acmd41 round
                        if (rx_byte == sd_bringup_pkg::R1_READY) begin
                            cmd        <= sd_bringup_pkg::SD_CMD17;
                            card_ready <= 1'b1;
                        end else begin
                            cmd <= sd_bringup_pkg::SD_CMD55;
                        end
                    end else if (rx_byte == sd_bringup_pkg::R1_READY) begin
                        state <= ST_TOKEN;
                    end
                end
                ST_TOKEN: if (xfer_done && rx_byte == sd_bringup_pkg::DATA_TOKEN) begin
                    cnt   <= 10'd0;
                    state <= ST_DATA;
                end
                ST_DATA: if (xfer_done) begin
                    state <= ST_HOLD;
                end
                ST_HOLD: if (data_ready) begin
                    if (cnt == 10'(sd_bringup_pkg::SECTOR_BYTES - 1)) begin
                        cnt   <= 10'd0;
                        state <= ST_CRC;
                    end else begin
                        cnt   <= cnt + 10'd1;
                        state <= ST_DATA;
                    end
                end
                ST_CRC: if (xfer_done) begin
                    cnt <= cnt + 10'd1;
                    if (cnt == 10'd1) begin
                        cs_n  <= 1'b1;
                        state <= ST_PARK;
                    end
                end
                default: state <= ST_PARK;
            endcase
        end
    end

endmodule

//--- logic/spi_byte_shifter.sv
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  tick,
    input  logic                  xfer_req,
    input  sd_bringup_pkg::byte_t tx_byte,
    input  logic                  SD_DAT0,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  xfer_done,
    output sd_bringup_pkg::byte_t rx_byte
);

    logic                  busy;
    logic [3:0]            edge_cnt;
    logic                  start;
    sd_bringup_pkg::byte_t shreg;

    // no restart in the done cycle, the request is still high there
    assign start   = xfer_req && !busy && !xfer_done;
    assign rx_byte = shreg;

    // ==============================
    // edge control
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy      <= 1'b0;
            edge_cnt  <= 4'd0;
            sclk      <= 1'b0;
            mosi      <= 1'b1;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                edge_cnt <= 4'd0;
                // msb set up before the first rising edge
                mosi     <= tx_byte[7];
            end else if (busy && tick) begin
                edge_cnt <= edge_cnt + 4'd1;
                // even count rises, odd count falls
                sclk     <= ~edge_cnt[0];
                if (edge_cnt == 4'd15) begin
                    busy      <= 1'b0;
                    xfer_done <= 1'b1;
                    mosi      <= 1'b1;
                end else if (edge_cnt[0]) begin
                    mosi <= shreg[7];
                end
            end
        end
    end

    // tx bits leave at the top, miso bits enter at the bottom
    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            shreg <= tx_byte;
        end else if (busy && tick && !edge_cnt[0]) begin
            shreg <= {shreg[6:0], SD_DAT0};
        end
    end

endmodule

//--- logic/wb_console_master.sv
`timescale 1ns/1ps

module wb_console_master #(
    parameter int console_adr = 0
) (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  logic                    char_valid,
    input  sd_bringup_pkg::byte_t   char_byte,
    output logic                    char_ready,
    output sd_bringup_pkg::wb_m2s_t console_wb,
    input  logic                    console_ack
);

    logic                  busy;
    sd_bringup_pkg::byte_t dat_q;

    // one write in flight, next char taken after ack
    assign char_ready = !busy;

    // cyc, stb and we move together
    always_comb begin
        console_wb.cyc = busy;
        console_wb.stb = busy;
        console_wb.we  = busy;
        console_wb.adr = 4'(console_adr);
        console_wb.dat = dat_q;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (console_ack) busy <= 1'b0;
        end else if (char_valid) begin
            busy <= 1'b1;
        end
    end

    // held stable for the whole cycle
    always_ff @(posedge CLOCK_50) begin
        if (!busy && char_valid) begin
            dat_q <= char_byte;
        end
    end

endmodule

//--- sd_bringup_top.f
logic/sd_bringup_pkg.sv
logic/board_timebase.sv
logic/spi_byte_shifter.sv
logic/sd_cmd_sequencer.sv
logic/hex_console_writer.sv
logic/wb_console_master.sv
logic/sd_bringup_top.sv
verif/sd_card_model.sv
verif/sd_bringup_tb.sv

//--- verif/sd_bringup_tb.sv
`timescale 1ns/1ps

module sd_bringup_tb;

    localparam int tick_div        = 4;
    localparam int heartbeat_width = 6;
    localparam int console_adr     = 0;
    localparam int total_chars     = 1 + 2 * sd_bringup_pkg::SECTOR_BYTES;
    localparam int led_half        = 1 << (heartbeat_width - 1);
    // twice the spi bytes plus console writes
    localparam int timeout_cycles  = 2 * (560 * 16 * tick_div + 1100 * 7);

    logic                    CLOCK_50;
    logic                    KEY0;
    logic                    LEDR0;
    logic                    SD_CLK;
    logic                    SD_CMD;
    logic                    SD_DAT0;
    logic                    SD_DAT3;
    sd_bringup_pkg::wb_m2s_t console_wb;
    logic                    console_ack;

    int                    card_frames;
    logic [47:0]           card_frame;
    sd_bringup_pkg::byte_t sector_img [sd_bringup_pkg::SECTOR_BYTES];
    int unsigned           ack_delay [1100];
    int                    test_errors [1:6];
    int                    total_errors = 0;
    int                    tests_failed = 0;
    int                    frames_seen = 0;
    int                    char_count = 0;
    int                    cycle_count = 0;
    sd_bringup_pkg::byte_t last_chars [4];

    // bus snapshots, taken at the falling edge
    sd_bringup_pkg::wb_m2s_t wb_now;
    sd_bringup_pkg::wb_m2s_t wb_prev;

    // heartbeat tracking
    logic led_last;
    logic led_event;
    logic led_seen;
    logic led_armed;
    int   led_gap;
    int   led_span;
    int   led_toggles;

    sd_bringup_top #(
        .tick_div        (tick_div),
        .heartbeat_width (heartbeat_width),
        .console_adr     (console_adr)
    ) dut (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .LEDR0       (LEDR0),
        .SD_CLK      (SD_CLK),
        .SD_CMD      (SD_CMD),
        .SD_DAT0     (SD_DAT0),
        .SD_DAT3     (SD_DAT3),
        .console_wb  (console_wb),
        .console_ack (console_ack)
    );

    sd_card_model card (
        .SD_CLK      (SD_CLK),
        .SD_CMD      (SD_CMD),
        .SD_DAT3     (SD_DAT3),
        .SD_DAT0     (SD_DAT0),
        .frame_count (card_frames),
        .last_frame  (card_frame)
    );

    // ==============================
    // reporting helpers
    // ==============================
    task automatic flag_value(input int n, input string sig,
                              input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] %0t ns test %0d %s expected %0h got %0h", $time, n, sig, exp, act);
        test_errors[n]++;
        total_errors++;
    endtask

    task automatic flag_event(input int n, input string what);
        $display("error at %0t ns in test %0d: %s", $time, n, what);
        test_errors[n]++;
        total_errors++;
    endtask

    task automatic close_test(input int n, input string name);
        $display("test %0d %s: %s", n, name, (test_errors[n] == 0) ? "ok" : "failed");
        if (test_errors[n] != 0) tests_failed++;
    endtask

    // command order of the bring-up
    function automatic sd_bringup_pkg::sd_cmd_t expected_cmd(input int n);
        case (n)
            0:       return sd_bringup_pkg::SD_CMD0;
            1, 3:    return sd_bringup_pkg::SD_CMD55;
            2, 4:    return sd_bringup_pkg::SD_ACMD41;
            default: return sd_bringup_pkg::SD_CMD17;
        endcase
    endfunction

    // start bits 01, index, arg, crc, stop bit
    function automatic logic [47:0] framed(input sd_bringup_pkg::sd_cmd_t c);
        return {2'b01, c.index, c.arg, c.crc, 1'b1};
    endfunction

    // banner first, then high and low digit per sector byte
    function automatic sd_bringup_pkg::byte_t expected_char(input int n);
        string                 digits = "0123456789ABCDEF";
        sd_bringup_pkg::byte_t b;
        if (n == 0) return "K";
        b = sector_img[(n - 1) / 2];
        if (n % 2 == 1) return digits[b[7:4]];
        return digits[b[3:0]];
    endfunction

    // ==============================
    // clock, watchdog
    // ==============================
    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge CLOCK_50);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d characters", cycle_count, char_count);
        $display(">>> FAIL");
        $finish;
    end

    // ==============================
    // assertions
    // ==============================
    reset_values: assert property (@(negedge CLOCK_50) !KEY0 |->
        ({SD_DAT3, SD_CLK, SD_CMD, console_wb.cyc, console_wb.stb, LEDR0} == 6'b101000))
        else flag_value(1, "{SD_DAT3,SD_CLK,SD_CMD,cyc,stb,LEDR0}", 6'b101000,
                        {SD_DAT3, SD_CLK, SD_CMD, console_wb.cyc, console_wb.stb, LEDR0});

    bus_together: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (console_wb.cyc == console_wb.stb) && (console_wb.stb == console_wb.we))
        else flag_value(5, "console_wb cyc/stb/we", {3{wb_now.cyc}},
                        {wb_now.cyc, wb_now.stb, wb_now.we});

    // request held unchanged while waiting for ack
    bus_stable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ($past(console_wb.stb) && !$past(console_ack)) |->
        (console_wb.stb && console_wb.adr == $past(console_wb.adr) &&
         console_wb.dat == $past(console_wb.dat)))
        else flag_value(5, "console_wb", wb_prev, wb_now);

    bus_release: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ($past(console_wb.stb) && $past(console_ack)) |-> !console_wb.cyc)
        else flag_value(5, "console_wb.cyc", 1'b0, wb_now.cyc);

    led_spacing: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (led_event && led_armed) |-> (led_span == led_half))
        else flag_value(6, "LEDR0 toggle spacing", led_half, led_span);

    always @(negedge CLOCK_50) begin
        wb_prev <= wb_now;
        wb_now  <= console_wb;
    end

    // clocks between LEDR0 toggles, first toggle only arms
    always @(negedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            led_last    <= 1'b0;
            led_event   <= 1'b0;
            led_seen    <= 1'b0;
            led_armed   <= 1'b0;
            led_gap     <= 0;
            led_span    <= 0;
            led_toggles <= 0;
        end else if (LEDR0 != led_last) begin
            led_last    <= LEDR0;
            led_span    <= led_gap;
            led_gap     <= 1;
            led_event   <= 1'b1;
            led_armed   <= led_seen;
            led_seen    <= 1'b1;
            led_toggles <= led_toggles + 1;
        end else begin
            led_gap   <= led_gap + 1;
            led_event <= 1'b0;
        end
    end

    // ==============================
    // card side monitor
    // ==============================
    initial begin : frame_monitor
        logic [47:0] want;
        logic        sclk_last;
        logic        selected;
        int          dummy_edges;
        sclk_last   = 1'b0;
        selected    = 1'b0;
        dummy_edges = 0;
        forever begin
            @(negedge CLOCK_50);
            if (KEY0 && !selected) begin
                if (SD_DAT3 && SD_CLK && !sclk_last) dummy_edges++;
                if (!SD_DAT3) begin
                    selected = 1'b1;
                    assert (dummy_edges >= 80)
                        else flag_value(2, "SD_CLK edges before select", 80, dummy_edges);
                end
            end
            sclk_last = SD_CLK;
            if (card_frames > frames_seen) begin
                assert (frames_seen < 6) else flag_event(2, "card saw an extra command frame");
                if (frames_seen < 6) begin
                    want = framed(expected_cmd(frames_seen));
                    assert (card_frame == want) else flag_value(2, "card frame", want, card_frame);
                end
                // cmd0 crc byte and sector-0 address
                if (frames_seen == 0) begin
                    assert (card_frame[7:0] == 8'h95)
                        else flag_value(2, "CMD0 crc byte", 8'h95, card_frame[7:0]);
                end
                if (frames_seen == 5) begin
                    assert (card_frame[39:8] == 32'd0)
                        else flag_value(2, "CMD17 argument", 32'd0, card_frame[39:8]);
                end
                frames_seen++;
            end
        end
    end

    // ==============================
    // console slave
    // ==============================
    initial begin : wb_slave
        sd_bringup_pkg::byte_t ch;
        int                    idx;
        console_ack = 1'b0;
        forever begin
            @(negedge CLOCK_50);
            if (KEY0 && console_wb.cyc && console_wb.stb) begin
                ch  = console_wb.dat;
                idx = char_count;
                char_count++;
                last_chars[idx % 4] = ch;
                assert (console_wb.we && console_wb.adr == 4'(console_adr))
                    else flag_value(5, "console_wb.adr", 4'(console_adr), console_wb.adr);
                assert (idx < total_chars)
                    else flag_event(4, "a character arrived after the boot signature");
                if (idx < total_chars) begin
                    assert (ch == expected_char(idx))
                        else flag_value((idx == 0) ? 3 : 4, "console_wb.dat",
                                        expected_char(idx), ch);
                end
                // random wait states before ack
                repeat (ack_delay[idx % 1100]) @(posedge CLOCK_50);
                @(posedge CLOCK_50);
                #2 console_ack = 1'b1;
                @(posedge CLOCK_50);
                #2 console_ack = 1'b0;
            end
        end
    end

    // ==============================
    // main sequence
    // ==============================
    initial begin : main_seq
        int unsigned seed_val;
        int          i;
        KEY0     = 1'b0;
        seed_val = $urandom(38330);
        for (i = 1; i <= 6; i++) begin
            test_errors[i] = 0;
        end
        for (i = 0; i < sd_bringup_pkg::SECTOR_BYTES; i++) begin
            sector_img[i] = 8'($urandom);
        end
        sector_img[510] = sd_bringup_pkg::BOOT_SIG_HI;
        sector_img[511] = sd_bringup_pkg::BOOT_SIG_LO;
        // no early signature pair
        for (i = 0; i < 509; i++) begin
            if (sector_img[i] == 8'h55 && sector_img[i + 1] == 8'hAA) sector_img[i + 1] = 8'hAB;
        end
        for (i = 0; i < sd_bringup_pkg::SECTOR_BYTES; i++) begin
            card.sector[i] = sector_img[i];
        end
        for (i = 0; i < 1100; i++) begin
            ack_delay[i] = $urandom_range(5, 0);
        end

        repeat (5) @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
        @(posedge CLOCK_50);
        close_test(1, "reset values");

        wait (frames_seen >= 6);
        close_test(2, "dummy clocks and command frames");
        wait (char_count >= 1);
        close_test(3, "ready banner");
        wait (char_count >= total_chars);
        // crc bytes and park, then quiet console
        repeat (8 * 16 * tick_div) @(posedge CLOCK_50);
        assert (SD_DAT3) else flag_value(4, "SD_DAT3 after sector", 1'b1, SD_DAT3);
        close_test(4, "sector hex dump");
        assert (char_count == total_chars) else flag_value(5, "char_count", total_chars, char_count);
        close_test(5, "console bus under ack delay");
        assert (led_toggles > 2) else flag_event(6, "LEDR0 hardly toggled");
        close_test(6, "heartbeat");

        $display("console tail %c%c%c%c", last_chars[0], last_chars[1], last_chars[2],
                 last_chars[3]);
        $display("tests 6, failed %0d, errors %0d, characters %0d, cycles %0d",
                 tests_failed, total_errors, char_count, cycle_count);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verif/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
    input  logic        SD_CLK,
    input  logic        SD_CMD,
    input  logic        SD_DAT3,
    output logic        SD_DAT0,
    output int          frame_count,
    output logic [47:0] last_frame
);

    // sector image, filled by the testbench before the card is selected
    sd_bringup_pkg::byte_t sector [sd_bringup_pkg::SECTOR_BYTES];

    // bytes queued for miso, 0xff when empty
    sd_bringup_pkg::byte_t reply_q [$];
    sd_bringup_pkg::byte_t rx_sr  = 8'hFF;
    sd_bringup_pkg::byte_t tx_sr  = 8'hFF;
    logic [47:0]           frame_sr = '0;
    logic [47:0]           frame_q  = '0;
    int                    bit_cnt  = 0;
    int                    frame_len = 0;
    int                    frames   = 0;
    int                    acmd41_count = 0;

    assign SD_DAT0     = SD_DAT3 ? 1'b1 : tx_sr[7];
    assign frame_count = frames;
    assign last_frame  = frame_q;

    // ==============================
    // command answers
    // ==============================
    task automatic answer(input logic [47:0] f);
        int i;
        // one fill byte so the host has to poll
        reply_q.push_back(8'hFF);
        case (f[45:40])
            6'd0, 6'd55: reply_q.push_back(sd_bringup_pkg::R1_IDLE);
            6'd41: begin
                acmd41_count++;
                // busy on the first try, ready after that
                if (acmd41_count < 2) begin
                    reply_q.push_back(sd_bringup_pkg::R1_IDLE);
                end else begin
                    reply_q.push_back(sd_bringup_pkg::R1_READY);
                end
            end
            6'd17: begin
                reply_q.push_back(sd_bringup_pkg::R1_READY);
                // access delay before the token
                for (i = 0; i < 3; i++) begin
                    reply_q.push_back(8'hFF);
                end
                reply_q.push_back(sd_bringup_pkg::DATA_TOKEN);
                for (i = 0; i < sd_bringup_pkg::SECTOR_BYTES; i++) begin
                    reply_q.push_back(sector[i]);
                end
                // data crc, not checked by the host
                reply_q.push_back(8'hC3);
                reply_q.push_back(8'h3C);
            end
            // illegal command bit
            default: reply_q.push_back(8'h04);
        endcase
    endtask

    // frame starts with 01, then five more bytes
    task automatic take_byte(input sd_bringup_pkg::byte_t b);
        if (frame_len == 0 && b[7:6] == 2'b01) begin
            frame_sr  = {40'd0, b};
            frame_len = 1;
        end else if (frame_len > 0) begin
            frame_sr  = {frame_sr[39:0], b};
            frame_len = frame_len + 1;
            if (frame_len == 6) begin
                frame_len = 0;
                frame_q   = frame_sr;
                frames    = frames + 1;
                answer(frame_sr);
            end
        end
    endtask

    // ==============================
    // spi mode 0 bit level
    // ==============================

    // mosi sampled on the rising edge
    always @(posedge SD_CLK) begin
        if (!SD_DAT3) begin
            rx_sr   = {rx_sr[6:0], SD_CMD};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(rx_sr);
            end
        end else begin
            bit_cnt = 0;
        end
    end

    // miso moves on the falling edge, next byte loaded after bit 8
    always @(negedge SD_CLK) begin
        if (!SD_DAT3) begin
            if (bit_cnt == 0) begin
                if (reply_q.size() > 0) begin
                    tx_sr = reply_q.pop_front();
                end else begin
                    tx_sr = 8'hFF;
                end
            end else begin
                tx_sr = {tx_sr[6:0], 1'b1};
            end
        end
    end

endmodule
